//--- Bender.yml
package:
  name: proc

sources:
  - procPkg.sv
  - exMemIf.sv
  - fetchStage.sv
  - decodeStage.sv
  - executeStage.sv
  - memoryStage.sv
  - proc.sv
  - target: test
    files:
      - tbClock.sv
      - procTb.sv

//--- all.f
procPkg.sv
exMemIf.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
proc.sv
tbClock.sv
procTb.sv

//--- decodeStage.sv
// decode stage: control decode and immediate extension,
// write-through register file, load-use hazard detect
// and the ID/EX pipeline register

`timescale 1ns/1ps

module decodeStage (
        input  logic             clk,
        input  logic             rst,
        input  procPkg::instrT   ifIdInstr,
        input  procPkg::dataT    ifIdPcNext,
        input  logic             branchTaken,
        input  logic             wbValid,
        input  procPkg::regAddrT wbRd,
        input  procPkg::dataT    wbData,
        input  logic             laterHalt,
        output logic             stall,
        output logic             haltSeen,
        output procPkg::dataT    idExRs1Val,
        output procPkg::dataT    idExRs2Val,
        output procPkg::dataT    idExImm,
        output procPkg::dataT    idExPcNext,
        output procPkg::regAddrT idExRs,
        output procPkg::regAddrT idExRt,
        output procPkg::regAddrT idExRd,
        output procPkg::aluOpT   idExAluOp,
        output logic             idExUseImm,
        output logic             idExRegWrite,
        output logic             idExMemRead,
        output logic             idExMemWrite,
        output logic             idExBranch,
        output logic             idExBranchNz,
        output logic             idExHalt,
        output logic             idExIllegal
);
        import procPkg::*;

        opcodeT  op;
        regAddrT rs, rt, rd;
        dataT    imm, rs1Val, rs2Val;
        aluOpT   aluOp;
        logic    useImm, regWrite, memRead, memWrite;
        logic    branch, branchNz, halt, illegal;
        dataT    regs [NUM_REGS];

        assign op = opcodeT'(ifIdInstr[15:11]);
        assign rs = ifIdInstr[10:8];
        assign rt = ifIdInstr[7:5];

        //////////////////////////////////////////////////
        // control decode
        //////////////////////////////////////////////////
        always_comb begin
                rd       = ifIdInstr[7:5];      // I-format dest
                aluOp    = ALU_ADD;             // address math for LD/ST
                useImm   = 1'b0;
                regWrite = 1'b0;
                memRead  = 1'b0;
                memWrite = 1'b0;
                branch   = 1'b0;
                branchNz = 1'b0;
                halt     = 1'b0;
                illegal  = 1'b0;
                case (op)
                        OP_ADD, OP_SUB, OP_AND, OP_XOR: begin
                                rd       = ifIdInstr[4:2];
                                aluOp    = aluOpT'(op[1:0]);    // low bits match aluOpT
                                regWrite = 1'b1;
                        end
                        OP_ADDI: begin
                                useImm   = 1'b1;
                                regWrite = 1'b1;
                        end
                        OP_LD: begin
                                useImm   = 1'b1;
                                regWrite = 1'b1;
                                memRead  = 1'b1;
                        end
                        OP_ST: begin
                                useImm   = 1'b1;
                                memWrite = 1'b1;
                        end
                        OP_BEQZ: branch = 1'b1;
                        OP_BNEZ: begin
                                branch   = 1'b1;
                                branchNz = 1'b1;
                        end
                        OP_HALT: halt = 1'b1;
                        OP_NOP:  ;
                        default: illegal = 1'b1;        // behaves as NOP otherwise
                endcase
        end

        // imm8 for branches, imm5 for everything else
        assign imm = branch ? {{8{ifIdInstr[7]}}, ifIdInstr[7:0]}
                            : {{11{ifIdInstr[4]}}, ifIdInstr[4:0]};

        //////////////////////////////////////////////////
        // register file
        //////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        for (int i = 0; i < NUM_REGS; i++)
                                regs[i] <= '0;
                end else if (wbValid) begin
                        regs[wbRd] <= wbData;
                end
        end

        // write-through, same-cycle WB result seen here
        assign rs1Val = (wbValid && wbRd == rs) ? wbData : regs[rs];
        assign rs2Val = (wbValid && wbRd == rt) ? wbData : regs[rt];

        // load in EX feeding IF/ID: one bubble
        assign stall    = idExMemRead && (idExRd == rs || idExRd == rt);
        assign haltSeen = (op == OP_HALT) || laterHalt;

        //////////////////////////////////////////////////
        // ID/EX register
        //////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst || branchTaken || stall) begin
                        idExUseImm   <= 1'b0;
                        idExRegWrite <= 1'b0;
                        idExMemRead  <= 1'b0;
                        idExMemWrite <= 1'b0;
                        idExBranch   <= 1'b0;
                        idExBranchNz <= 1'b0;
                        idExHalt     <= 1'b0;
                        idExIllegal  <= 1'b0;
                end else begin
                        idExUseImm   <= useImm;
                        idExRegWrite <= regWrite;
                        idExMemRead  <= memRead;
                        idExMemWrite <= memWrite;
                        idExBranch   <= branch;
                        idExBranchNz <= branchNz;
                        idExHalt     <= halt;
                        idExIllegal  <= illegal;
                end
        end

        always_ff @(posedge clk) begin
                idExRs1Val <= rs1Val;
                idExRs2Val <= rs2Val;
                idExImm    <= imm;
                idExPcNext <= ifIdPcNext;
                idExRs     <= rs;
                idExRt     <= rt;
                idExRd     <= rd;
                idExAluOp  <= aluOp;
        end

        // MEM/WB register never hands an unknown dest to the file
        assert property (@(posedge clk) disable iff (rst) wbValid |-> !$isunknown(wbRd));

endmodule

//--- exMemIf.sv
// EX/MEM pipeline register bundle
// src side written by execute, dst side read by memory

`timescale 1ns/1ps

interface exMemIf;
        import procPkg::*;

        logic    regWrite;      // result goes to rd
        logic    memRead;       // LD
        logic    memWrite;      // ST
        logic    halt;
        logic    illegal;       // bad opcode, travels to err
        regAddrT rd;
        dataT    aluOut;        // result or memory address
        dataT    storeData;     // forwarded rt for ST

        modport src (output regWrite, memRead, memWrite, halt, illegal,
                     output rd, aluOut, storeData);
        modport dst (input regWrite, memRead, memWrite, halt, illegal,
                     input rd, aluOut, storeData);

endinterface

//--- executeStage.sv
// execute stage: EX/MEM and MEM/WB forwarding, ALU,
// branch resolution and the EX/MEM register

`timescale 1ns/1ps

module executeStage (
        input  logic             clk,
        input  logic             rst,
        input  procPkg::dataT    idExRs1Val,
        input  procPkg::dataT    idExRs2Val,
        input  procPkg::dataT    idExImm,
        input  procPkg::dataT    idExPcNext,
        input  procPkg::regAddrT idExRs,
        input  procPkg::regAddrT idExRt,
        input  procPkg::regAddrT idExRd,
        input  procPkg::aluOpT   idExAluOp,
        input  logic             idExUseImm,
        input  logic             idExRegWrite,
        input  logic             idExMemRead,
        input  logic             idExMemWrite,
        input  logic             idExBranch,
        input  logic             idExBranchNz,
        input  logic             idExHalt,
        input  logic             idExIllegal,
        input  logic             wbValid,
        input  procPkg::regAddrT wbRd,
        input  procPkg::dataT    wbData,
        output logic             branchTaken,
        output procPkg::dataT    branchTarget,
        exMemIf.src              exMem
);
        import procPkg::*;

        dataT opA, opB, aluB, aluOut;
        logic isZero;

        // newest producer wins: EX/MEM, then MEM/WB, then regfile value
        function automatic dataT fwdSel(input regAddrT src, input dataT idVal);
                if (exMem.regWrite && exMem.rd == src)
                        return exMem.aluOut;
                else if (wbValid && wbRd == src)
                        return wbData;
                else
                        return idVal;
        endfunction

        assign opA  = fwdSel(idExRs, idExRs1Val);
        assign opB  = fwdSel(idExRt, idExRs2Val);      // also the ST data
        assign aluB = idExUseImm ? idExImm : opB;

        //////////////////////////////////////////////////
        // ALU
        //////////////////////////////////////////////////
        always_comb begin
                case (idExAluOp)
                        ALU_ADD: aluOut = opA + aluB;
                        ALU_SUB: aluOut = opA - aluB;   // rs - rt
                        ALU_AND: aluOut = opA & aluB;
                        default: aluOut = opA ^ aluB;
                endcase
        end

        // branch tests the forwarded rs
        assign isZero       = (opA == '0);
        assign branchTaken  = idExBranch && (idExBranchNz ? !isZero : isZero);
        assign branchTarget = idExPcNext + idExImm;

        //////////////////////////////////////////////////
        // EX/MEM register
        //////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        exMem.regWrite <= 1'b0;
                        exMem.memRead  <= 1'b0;
                        exMem.memWrite <= 1'b0;
                        exMem.halt     <= 1'b0;
                        exMem.illegal  <= 1'b0;
                end else begin
                        exMem.regWrite <= idExRegWrite;
                        exMem.memRead  <= idExMemRead;
                        exMem.memWrite <= idExMemWrite;
                        exMem.halt     <= idExHalt;
                        exMem.illegal  <= idExIllegal;
                end
        end

        always_ff @(posedge clk) begin
                exMem.rd        <= idExRd;
                exMem.aluOut    <= aluOut;
                exMem.storeData <= opB;
        end

        // younger slot squashed after a redirect, no second branch behind it
        assert property (@(posedge clk) disable iff (rst)
                branchTaken |=> !(idExBranch || idExRegWrite || idExMemWrite || idExHalt));

endmodule

//--- fetchStage.sv
// fetch stage: program counter, loadable instruction memory
// and the IF/ID register with stall, flush and halt handling

`timescale 1ns/1ps

module fetchStage (
        input  logic           clk,
        input  logic           rst,
        input  logic           stall,
        input  logic           haltSeen,
        input  logic           branchTaken,
        input  procPkg::dataT  branchTarget,
        input  logic           imemWe,
        input  procPkg::dataT  imemAddr,
        input  procPkg::instrT imemData,
        output procPkg::instrT ifIdInstr,
        output procPkg::dataT  ifIdPcNext
);
        import procPkg::*;

        instrT imem [IMEM_WORDS];
        dataT  pc;
        dataT  pcNext;
        instrT instr;

        assign pcNext = pc + 16'd2;
        assign instr  = imem[pc[IMEM_AW:1]];    // async read

        // program load port, used while rst is high
        always_ff @(posedge clk) begin
                if (imemWe)
                        imem[imemAddr[IMEM_AW:1]] <= imemData;
        end

        always_ff @(posedge clk) begin
                if (rst)
                        pc <= '0;
                else if (branchTaken)
                        pc <= branchTarget;     // resolved in EX
                else if (!(stall || haltSeen))
                        pc <= pcNext;
        end

        //////////////////////////////////////////////////
        // IF/ID register
        //////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst || branchTaken)
                        ifIdInstr <= NOP_INSTR;
                else if (stall)
                        ifIdInstr <= ifIdInstr; // keep a HALT held behind a load too
                else if (haltSeen)
                        ifIdInstr <= NOP_INSTR; // nothing past HALT enters decode
                else
                        ifIdInstr <= instr;
        end

        always_ff @(posedge clk) begin
                if (!stall)
                        ifIdPcNext <= pcNext;
        end

        // word aligned fetch, including targets coming back from EX
        assert property (@(posedge clk) disable iff (rst) pc[0] == 1'b0);

endmodule

//--- memoryStage.sv
// memory stage: data memory, writeback select
// and the MEM/WB register feeding regfile, forwarding and trace

`timescale 1ns/1ps

module memoryStage (
        input  logic             clk,
        input  logic             rst,
        exMemIf.dst              exMem,
        output logic             wbValid,
        output procPkg::regAddrT wbRd,
        output procPkg::dataT    wbData,
        output logic             wbHalt,
        output logic             wbIllegal
);
        import procPkg::*;

        dataT dmem [DMEM_WORDS];
        dataT loadData;

        always_ff @(posedge clk) begin
                if (exMem.memWrite)
                        dmem[exMem.aluOut[DMEM_AW:1]] <= exMem.storeData;
        end

        assign loadData = dmem[exMem.aluOut[DMEM_AW:1]];       // async read in MEM

        //////////////////////////////////////////////////
        // MEM/WB register
        //////////////////////////////////////////////////
        always_ff @(posedge clk) begin
                if (rst) begin
                        wbValid   <= 1'b0;
                        wbHalt    <= 1'b0;
                        wbIllegal <= 1'b0;
                end else begin
                        wbValid   <= exMem.regWrite;
                        wbHalt    <= exMem.halt;
                        wbIllegal <= exMem.illegal;
                end
        end

        always_ff @(posedge clk) begin
                wbRd   <= exMem.rd;
                wbData <= exMem.memRead ? loadData : exMem.aluOut;
        end

endmodule

//--- proc.sv
// top level of the five-stage pipeline
// stage wiring, writeback trace and sticky halted/err flags

`timescale 1ns/1ps

module proc (
        input  logic             clk,
        input  logic             rst,
        input  logic             imemWe,
        input  procPkg::dataT    imemAddr,
        input  procPkg::instrT   imemData,
        output logic             wbValid,
        output procPkg::regAddrT wbRd,
        output procPkg::dataT    wbData,
        output logic             halted,
        output logic             err
);
        import procPkg::*;

        instrT   ifIdInstr;
        dataT    ifIdPcNext, branchTarget;
        logic    stall, haltSeen, branchTaken, laterHalt, wbHalt, wbIllegal;
        dataT    idExRs1Val, idExRs2Val, idExImm, idExPcNext;
        regAddrT idExRs, idExRt, idExRd;
        aluOpT   idExAluOp;
        logic    idExUseImm, idExRegWrite, idExMemRead, idExMemWrite;
        logic    idExBranch, idExBranchNz, idExHalt, idExIllegal;

        exMemIf exMemBus ();

        // any halt still in flight keeps fetch frozen, and so does a retired one
        assign laterHalt = idExHalt || exMemBus.halt || wbHalt || halted;

        fetchStage u_fetch (
                .clk, .rst, .stall, .haltSeen, .branchTaken, .branchTarget,
                .imemWe, .imemAddr, .imemData, .ifIdInstr, .ifIdPcNext
        );

        decodeStage u_decode (
                .clk, .rst, .ifIdInstr, .ifIdPcNext, .branchTaken,
                .wbValid, .wbRd, .wbData, .laterHalt, .stall, .haltSeen,
                .idExRs1Val, .idExRs2Val, .idExImm, .idExPcNext,
                .idExRs, .idExRt, .idExRd, .idExAluOp, .idExUseImm,
                .idExRegWrite, .idExMemRead, .idExMemWrite,
                .idExBranch, .idExBranchNz, .idExHalt, .idExIllegal
        );

        executeStage u_execute (
                .clk, .rst, .idExRs1Val, .idExRs2Val, .idExImm, .idExPcNext,
                .idExRs, .idExRt, .idExRd, .idExAluOp, .idExUseImm,
                .idExRegWrite, .idExMemRead, .idExMemWrite,
                .idExBranch, .idExBranchNz, .idExHalt, .idExIllegal,
                .wbValid, .wbRd, .wbData, .branchTaken, .branchTarget,
                .exMem(exMemBus.src)
        );

        memoryStage u_memory (
                .clk, .rst, .exMem(exMemBus.dst),
                .wbValid, .wbRd, .wbData, .wbHalt, .wbIllegal
        );

        // set the cycle after HALT/illegal leaves MEM/WB, held until reset
        always_ff @(posedge clk) begin
                if (rst) begin
                        halted <= 1'b0;
                        err    <= 1'b0;
                end else begin
                        halted <= halted || wbHalt;
                        err    <= err || wbIllegal;
                end
        end

endmodule

//--- procPkg.sv
// shared widths and types for the 16-bit pipeline
// opcode and ALU operation encodings
// memory sizes and the NOP instruction word

package procPkg;

        typedef logic [15:0] dataT;     // word or byte address
        typedef logic [2:0]  regAddrT;  // register number
        typedef logic [15:0] instrT;    // instruction word

        // opcode sits in instr[15:11]
        typedef enum logic [4:0] {
                OP_HALT = 5'b00000,
                OP_NOP  = 5'b00001,
                OP_ADDI = 5'b01000,
                OP_BEQZ = 5'b01100,
                OP_BNEZ = 5'b01101,
                OP_ST   = 5'b10000,
                OP_LD   = 5'b10001,
                OP_ADD  = 5'b11000,
                OP_SUB  = 5'b11001,
                OP_AND  = 5'b11010,
                OP_XOR  = 5'b11011
        } opcodeT;

        typedef enum logic [1:0] {
                ALU_ADD = 2'b00,
                ALU_SUB = 2'b01,
                ALU_AND = 2'b10,
                ALU_XOR = 2'b11
        } aluOpT;

        //////////////////////////////////////////////////
        // memories, word index from address bits 8..1
        //////////////////////////////////////////////////
        localparam int IMEM_WORDS = 256;
        localparam int DMEM_WORDS = 256;
        localparam int IMEM_AW    = 8;
        localparam int DMEM_AW    = 8;
        localparam int NUM_REGS   = 8;

        // bubble word used by fetch on reset, flush and halt
        localparam instrT NOP_INSTR = {OP_NOP, 11'b0};

endpackage

//--- procTb.sv
// testbench for the pipelined processor
// instruction encoders, program loader, writeback trace collector,
// compare tasks and the directed tests

`timescale 1ns/1ps

module procTb;
        import procPkg::*;

        logic    clk, rst, rstReq;
        logic    imemWe;
        dataT    imemAddr;
        instrT   imemData;
        logic    wbValid, halted, err;
        regAddrT wbRd;
        dataT    wbData;

        int      errCount;
        instrT   prog[$];               // program of the current test
        regAddrT expRd[$], gotRd[$];
        dataT    expData[$], gotData[$];

        tbClock u_clk (.rstReq, .clk, .rst);

        proc i_dut (
                .clk, .rst, .imemWe, .imemAddr, .imemData,
                .wbValid, .wbRd, .wbData, .halted, .err
        );

        //////////////////////////////////////////////////
        // instruction encoders and ISA helpers
        //////////////////////////////////////////////////
        function automatic instrT rType(opcodeT op, regAddrT rd, regAddrT rs, regAddrT rt);
                return {op, rs, rt, rd, 2'b00};
        endfunction

        // rt is the dest for ADDI/LD, the data source for ST
        function automatic instrT iType(opcodeT op, regAddrT rt, regAddrT rs, logic [4:0] imm);
                return {op, rs, rt, imm};
        endfunction

        function automatic instrT bType(opcodeT op, regAddrT rs, logic [7:0] off);
                return {op, rs, off};
        endfunction

        function automatic dataT sext5(logic [4:0] v);
                logic signed [15:0] t;
                t = $signed(v);         // signed widening
                return dataT'(t);
        endfunction

        //////////////////////////////////////////////////
        // compare tasks
        //////////////////////////////////////////////////
        task automatic checkReg(string name, regAddrT got, regAddrT exp);
                if (got !== exp) begin
                        errCount++;
                        $display("** Error: %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic checkData(string name, dataT got, dataT exp);
                if (got !== exp) begin
                        errCount++;
                        $display("** Error: %s got %h expected %h", name, got, exp);
                end
        endtask

        task automatic checkFlag(string name, logic got, logic exp);
                if (got !== exp) begin
                        errCount++;
                        $display("** Error: %s got %h expected %h", name, got, exp);
                end
        endtask

        //////////////////////////////////////////////////
        // loader and trace collector
        //////////////////////////////////////////////////
        task automatic newTest();
                prog.delete();
                expRd.delete();
                expData.delete();
                gotRd.delete();
                gotData.delete();
        endtask

        task automatic expectWb(regAddrT rd, dataT d);
                expRd.push_back(rd);
                expData.push_back(d);
        endtask

        task automatic sampleTrace();
                @(negedge clk);         // outputs settled mid-cycle
                if (wbValid) begin
                        gotRd.push_back(wbRd);
                        gotData.push_back(wbData);
                end
        endtask

        task automatic runProgram();
                int cycles;
                @(posedge clk);
                rstReq <= 1'b1;
                foreach (prog[i]) begin
                        @(posedge clk);
                        imemWe   <= 1'b1;
                        imemAddr <= dataT'(2 * i);      // byte address
                        imemData <= prog[i];
                end
                @(posedge clk);
                imemWe <= 1'b0;
                @(posedge clk);
                rstReq <= 1'b0;
                cycles = 0;
                while (rst && cycles < 20) begin        // power-on reset may still be up
                        @(negedge clk);
                        cycles++;
                end
                if (rst) begin
                        errCount++;
                        $display("Reset did not release within 20 cycles");
                end
                cycles = 0;
                while (!halted && cycles < 200) begin
                        sampleTrace();
                        cycles++;
                end
                if (!halted) begin
                        errCount++;
                        $display("Timeout: halted did not rise within 200 cycles");
                end
                repeat (6) sampleTrace();       // nothing may retire after the halt
        endtask

        task automatic compareTrace(string name, logic expErr);
                int n;
                n = (gotRd.size() < expRd.size()) ? gotRd.size() : expRd.size();
                for (int i = 0; i < n; i++) begin
                        checkReg($sformatf("%s wbRd[%0d]", name, i), gotRd[i], expRd[i]);
                        checkData($sformatf("%s wbData[%0d]", name, i), gotData[i], expData[i]);
                end
                if (gotRd.size() != expRd.size()) begin
                        errCount++;
                        $display("%s: saw %0d writebacks but expected %0d",
                                 name, gotRd.size(), expRd.size());
                end
                checkFlag($sformatf("%s err", name), err, expErr);
                checkFlag($sformatf("%s halted", name), halted, 1'b1);
        endtask

        //////////////////////////////////////////////////
        // directed tests
        //////////////////////////////////////////////////
        // each op uses the one before it, EX/MEM and MEM/WB forwarding
        task automatic aluChain();
                logic [4:0] a, b;
                dataT       r1, r2, r3, r4, r5, r6;
                a  = 5'($urandom);
                b  = 5'($urandom);
                r1 = sext5(a);
                r2 = sext5(b);
                r3 = r1 + r2;
                r4 = r3 - r2;
                r5 = r4 & r3;
                r6 = r5 ^ r4;
                newTest();
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, a));
                prog.push_back(iType(OP_ADDI, 3'd2, 3'd0, b));
                prog.push_back(rType(OP_ADD, 3'd3, 3'd1, 3'd2));
                prog.push_back(rType(OP_SUB, 3'd4, 3'd3, 3'd2));
                prog.push_back(rType(OP_AND, 3'd5, 3'd4, 3'd3));
                prog.push_back(rType(OP_XOR, 3'd6, 3'd5, 3'd4));
                prog.push_back({OP_HALT, 11'b0});
                expectWb(3'd1, r1);
                expectWb(3'd2, r2);
                expectWb(3'd3, r3);
                expectWb(3'd4, r4);
                expectWb(3'd5, r5);
                expectWb(3'd6, r6);
                runProgram();
                compareTrace("aluChain", 1'b0);
        endtask

        task automatic negImm();
                logic [4:0] n1, n2, n3;
                n1 = {1'b1, 4'($urandom)};      // sign bit forced
                n2 = {1'b1, 4'($urandom)};
                n3 = {1'b1, 4'($urandom)};
                newTest();
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, n1));
                prog.push_back(iType(OP_ADDI, 3'd2, 3'd1, n2));
                prog.push_back(iType(OP_ADDI, 3'd3, 3'd2, n3));
                prog.push_back({OP_HALT, 11'b0});
                expectWb(3'd1, sext5(n1));
                expectWb(3'd2, sext5(n1) + sext5(n2));
                expectWb(3'd3, sext5(n1) + sext5(n2) + sext5(n3));
                runProgram();
                compareTrace("negImm", 1'b0);
        endtask

        // ADD right after LD needs the one-cycle bubble
        task automatic storeLoad();
                logic [4:0] v, base, off;
                dataT       val;
                v    = 5'($urandom);
                base = {1'b0, 4'($urandom)};
                off  = {2'b00, 3'($urandom)};
                val  = sext5(v);
                newTest();
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, v));
                prog.push_back(iType(OP_ADDI, 3'd2, 3'd0, base));
                prog.push_back(iType(OP_ST, 3'd1, 3'd2, off));
                prog.push_back(iType(OP_LD, 3'd3, 3'd2, off));
                prog.push_back(rType(OP_ADD, 3'd4, 3'd3, 3'd1));
                prog.push_back({OP_HALT, 11'b0});
                expectWb(3'd1, val);
                expectWb(3'd2, sext5(base));
                expectWb(3'd3, val);
                expectWb(3'd4, val + val);
                runProgram();
                compareTrace("storeLoad", 1'b0);
        endtask

        task automatic branches();
                logic [4:0] k;
                k = 5'($urandom) | 5'd1;        // nonzero, later overwritten with 0
                newTest();
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, k));          // 0
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, 5'd0));       // 2
                prog.push_back(bType(OP_BEQZ, 3'd1, 8'd4));             // 4, to 10
                prog.push_back(iType(OP_ADDI, 3'd2, 3'd0, 5'd1));       // flushed
                prog.push_back(iType(OP_ADDI, 3'd3, 3'd0, 5'd2));       // flushed
                prog.push_back(bType(OP_BNEZ, 3'd1, 8'd4));             // 10, falls through
                prog.push_back(iType(OP_ADDI, 3'd5, 3'd0, 5'd3));
                prog.push_back(iType(OP_ADDI, 3'd6, 3'd0, 5'd4));
                prog.push_back({OP_HALT, 11'b0});                       // 16
                expectWb(3'd1, sext5(k));
                expectWb(3'd1, 16'd0);
                expectWb(3'd5, 16'd3);
                expectWb(3'd6, 16'd4);
                runProgram();
                compareTrace("branches", 1'b0);
        endtask

        task automatic haltStop();
                logic [4:0] x, y;
                x = 5'($urandom);
                y = 5'($urandom);
                newTest();
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, x));
                prog.push_back(iType(OP_ADDI, 3'd2, 3'd1, y));
                prog.push_back({OP_HALT, 11'b0});
                prog.push_back(iType(OP_ADDI, 3'd3, 3'd0, 5'd1));       // never retires
                prog.push_back(iType(OP_ADDI, 3'd4, 3'd0, 5'd2));
                expectWb(3'd1, sext5(x));
                expectWb(3'd2, sext5(x) + sext5(y));
                runProgram();
                compareTrace("haltStop", 1'b0);
        endtask

        task automatic illegalOp();
                logic [4:0] a, b;
                a = 5'($urandom);
                b = 5'($urandom);
                newTest();
                prog.push_back(iType(OP_ADDI, 3'd1, 3'd0, a));
                prog.push_back(instrT'({5'b00010, 11'h123}));   // unused opcode
                prog.push_back(iType(OP_ADDI, 3'd2, 3'd1, b));
                prog.push_back({OP_HALT, 11'b0});
                expectWb(3'd1, sext5(a));
                expectWb(3'd2, sext5(a) + sext5(b));
                runProgram();
                compareTrace("illegalOp", 1'b1);
        endtask

        initial begin
                void'($urandom(13320));
                errCount = 0;
                rstReq   = 1'b1;
                imemWe   = 1'b0;
                imemAddr = '0;
                imemData = '0;
                aluChain();
                negImm();
                storeLoad();
                branches();
                haltStop();
                illegalOp();
                $display("Errors: %0d", errCount);
                if (errCount == 0)
                        $display("Simulation passed");
                else
                        $display("Simulation failed");
                $finish;
        end

endmodule

//--- tbClock.sv
// testbench clock and reset
// 8 ns period, reset held for the first 10 cycles
// and again whenever the tests request it

`timescale 1ns/1ps

module tbClock (
        input  logic rstReq,            // test-driven reset hold
        output logic clk,
        output logic rst
);
        logic porRst;

        initial clk = 1'b0;
        always #4 clk = ~clk;

        initial begin
                porRst = 1'b1;
                repeat (10) @(posedge clk);
                porRst <= 1'b0;
        end

        assign rst = porRst || rstReq;

endmodule
